/* core_stim.txt */
// columns: instruction word, control (bits 3:0 expected commit register,
// bit 8 set means a reset follows and no commit is expected), expected commit value
// move-immediate, positive and negative
21000005 001 00000005
2200fffd 002 fffffffd
23007fff 003 00007fff
24008000 004 ffff8000
25001234 005 00001234
2600ffff 006 ffffffff
// add and sub with wrap
07120000 007 00000002
18120000 008 00000008
09660000 009 fffffffe
1a430000 00a ffff0001
0b360000 00b 00007ffe
1c060000 00c 00000001
0d440000 00d ffff0000
// dependent chain
21000010 001 00000010
01110000 001 00000020
02110000 002 00000040
13210000 003 00000020
01320000 001 00000060
14130000 004 00000040
05410000 005 000000a0
// multiplies mixed with alu operations
26000007 006 00000007
37560000 007 00000460
28000003 008 00000003
09880000 009 00000006
3a980000 00a 00000012
1b790000 00b 0000045a
3c770000 00c 00132400
0dca0000 00d 00132412
2e008001 00e ffff8001
3fee0000 00f 3fff0001
31260000 001 000001c0
021f0000 002 3fff01c1
// long run of independent multiplies
3a340000 00a 00000800
3b560000 00b 00000460
3c890000 00c 00000012
3d440000 00d 00001000
37660000 007 00000031
31e60000 001 fffc8007
3a550000 00a 00006400
3b930000 00b 000000c0
3cf80000 00c bffd0003
3d680000 00d 00000015
37490000 007 00000180
31330000 001 00000400
02ac0000 002 bffd6403
13d10000 003 fffffc15
// multiply in flight when reset hits, then a fresh sequence from zero
34560000 100 00000000
01120000 001 00000000
12340000 002 00000000
23000009 003 00000009
04370000 004 00000009
35430000 005 00000051
165f0000 006 00000051
2000fff0 000 fffffff0
37060000 007 fffffaf0
08700000 008 fffffae0
39880000 009 001a4400
1a950000 00a 001a43af

/* filelist.f */
+incdir+.
core_pkg.sv
issue_if.sv
issue_decode.sv
reg_status.sv
exec_units.sv
cdb_arbiter.sv
reorder_buffer.sv
core_top.sv
core_tb.sv

/* Bender.yml */
package:
  name: ooo_core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - issue_if.sv
      - issue_decode.sv
      - reg_status.sv
      - exec_units.sv
      - cdb_arbiter.sv
      - reorder_buffer.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_tb.sv

/* core_tb.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;
	localparam int    CLK_PERIOD     = 10;
	localparam int    RESET_CYCLES   = 16;
	localparam int    N_LINES        = 58;
	localparam int    TIMEOUT_CYCLES = 20 * N_LINES + 100;
	localparam string STIM_FILE      = "core_stim.txt";

	logic               clk;
	logic               arst_n;
	logic               inst_valid;
	logic [31:0]        inst;
	logic               inst_ready;
	logic               commit_valid;
	logic [`REG_W-1:0]  commit_reg;
	logic [`DATA_W-1:0] commit_data;

	// three words per line: instruction, control, value
	logic [31:0]        stim_mem [3*N_LINES];
	logic [`REG_W-1:0]  exp_reg [N_LINES];
	logic [`DATA_W-1:0] exp_val [N_LINES];
	int                 n_expected = 0;
	int                 commit_idx = 0;
	int                 cycle_cnt = 0;
	logic [31:0]        rng_state = 32'h7839777d;

	core_top uut (
		.clk, .arst_n, .inst_valid, .inst, .inst_ready,
		.commit_valid, .commit_reg, .commit_data
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run(input string why);
		$display("%s (at %0t ns)", why, $time);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
	                           input string what);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// lines with control bit 8 set produce no commit
	task automatic load_expected();
		$readmemh(STIM_FILE, stim_mem);
		if ($isunknown(stim_mem[3*N_LINES-1]))
			fail_run("stimulus file is missing or shorter than expected");
		for (int n = 0; n < N_LINES; n++) begin
			if (!stim_mem[3*n+1][8]) begin
				exp_reg[n_expected] = stim_mem[3*n+1][`REG_W-1:0];
				exp_val[n_expected] = stim_mem[3*n+2];
				n_expected++;
			end
		end
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send_inst(input logic [31:0] word);
		int   gap;
		logic taken;
		rng_state = xorshift32(rng_state);
		gap = rng_state % 4;
		inst_valid = 1'b0;
		repeat (gap) @(negedge clk);
		inst_valid = 1'b1;
		inst       = word;
		taken      = 1'b0;
		while (!taken) begin
			#(CLK_PERIOD/2 - 1);
			taken = inst_ready;
			@(negedge clk);
		end
		inst_valid = 1'b0;
	endtask

	task automatic reset_core();
		inst_valid = 1'b0;
		arst_n     = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commit monitor, samples just before the rising edge
	////////////////////////////////////////////////////////////////////////////
	initial begin
		forever begin
			@(negedge clk);
			#(CLK_PERIOD/2 - 1);
			if (arst_n && commit_valid) begin
				if (commit_idx >= n_expected) begin
					fail_run("a commit appeared after every expected result had retired");
				end else begin
					check_value(commit_reg, exp_reg[commit_idx],
						$sformatf("commit %0d register", commit_idx));
					check_value(commit_data, exp_val[commit_idx],
						$sformatf("commit %0d value", commit_idx));
					commit_idx++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES)
			fail_run($sformatf("timeout: only %0d of %0d results committed", commit_idx, n_expected));
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin : main_seq
		int          sent_expected;
		logic [31:0] word;
		logic [31:0] ctrl;
		sent_expected = 0;
		arst_n        = 1'b0;
		inst_valid    = 1'b0;
		inst          = '0;
		load_expected();
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;

		for (int n = 0; n < N_LINES; n++) begin
			word = stim_mem[3*n];
			ctrl = stim_mem[3*n+1];
			if (ctrl[8]) begin
				// drain first, so only this instruction is lost to the reset
				while (commit_idx < sent_expected)
					@(negedge clk);
				send_inst(word);
				reset_core();
			end else begin
				send_inst(word);
				sent_expected++;
			end
		end

		while (commit_idx < n_expected)
			@(negedge clk);
		// a few idle cycles to catch a duplicated commit
		repeat (10) @(negedge clk);

		if (commit_idx == n_expected) begin
			$display("TEST PASS");
			$finish;
		end else begin
			fail_run($sformatf("commit count %0d does not match %0d lines", commit_idx, n_expected));
		end
	end
endmodule

/* core_top.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               inst_valid,
	input  logic [31:0]        inst,
	output logic               inst_ready,
	output logic               commit_valid,
	output logic [`REG_W-1:0]  commit_reg,
	output logic [`DATA_W-1:0] commit_data
);
	////////////////////////////////////////////////////////////////////////////
	// wires
	////////////////////////////////////////////////////////////////////////////
	issue_if iss ();

	logic [`REG_W-1:0]  rs1;
	logic [`REG_W-1:0]  rs2;
	logic [`DATA_W-1:0] src_val [2];
	logic               src_pend [2];
	tag_t               src_tag [2];
	logic               rob_full;
	tag_t               rob_tail;
	logic               rob_done [2];
	logic [`DATA_W-1:0] rob_data [2];
	logic               alloc;
	logic [`REG_W-1:0]  alloc_rd;
	tag_t               commit_tag;
	logic [`DATA_W-1:0] alu_data;
	logic [`DATA_W-1:0] mul_data;
	cdb_t               cdb;

	////////////////////////////////////////////////////////////////////////////
	// instances
	////////////////////////////////////////////////////////////////////////////
	issue_decode u_decode (
		.clk, .arst_n, .inst_valid, .inst(inst_t'(inst)), .inst_ready, .iss, .cdb,
		.rs1, .rs2, .src_val, .src_pend, .src_tag,
		.rob_full, .rob_tail, .rob_done, .rob_data, .alloc, .alloc_rd
	);

	reg_status u_regs (
		.clk, .arst_n, .rs1, .rs2, .src_val, .src_pend, .src_tag,
		.issue(alloc), .issue_rd(alloc_rd), .issue_tag(rob_tail),
		.commit(commit_valid), .commit_reg, .commit_tag, .commit_data
	);

	exec_units u_exec (.clk, .arst_n, .iss, .alu_data, .mul_data);

	cdb_arbiter u_cdb (.clk, .arst_n, .iss, .alu_data, .mul_data, .cdb);

	// lookups follow the pending tags of the two sources
	reorder_buffer u_rob (
		.clk, .arst_n, .alloc, .alloc_rd, .rob_full, .rob_tail,
		.look_tag(src_tag), .rob_done, .rob_data, .cdb,
		.commit_valid, .commit_reg, .commit_tag, .commit_data
	);
endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module reorder_buffer import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               alloc,
	input  logic [`REG_W-1:0]  alloc_rd,
	output logic               rob_full,
	output tag_t               rob_tail,
	input  tag_t               look_tag [2],
	output logic               rob_done [2],
	output logic [`DATA_W-1:0] rob_data [2],
	input  cdb_t               cdb,
	output logic               commit_valid,
	output logic [`REG_W-1:0]  commit_reg,
	output tag_t               commit_tag,
	output logic [`DATA_W-1:0] commit_data
);
	logic [`REG_W-1:0]  dest [`ROB_DEPTH];
	logic [`DATA_W-1:0] data [`ROB_DEPTH];
	logic               done [`ROB_DEPTH];
	tag_t               head;
	tag_t               tail;
	logic [`ROB_W:0]    count;

	////////////////////////////////////////////////////////////////////////////
	// pointers and done flags
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++)
				done[i] <= 1'b0;
		end else begin
			if (cdb.valid)
				done[cdb.tag] <= 1'b1;
			if (alloc) begin
				done[tail] <= 1'b0;
				tail       <= tail + 1'b1;
			end
			if (commit_valid)
				head <= head + 1'b1;
			count <= count + alloc - commit_valid;
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (alloc)
			dest[tail] <= alloc_rd;
		if (cdb.valid)
			data[cdb.tag] <= cdb.data;
	end

	assign rob_full = (count == `ROB_DEPTH);
	assign rob_tail = tail;

	for (genvar i = 0; i < 2; i++) begin : g_look
		assign rob_done[i] = done[look_tag[i]];
		assign rob_data[i] = data[look_tag[i]];
	end

	////////////////////////////////////////////////////////////////////////////
	// in-order retire, one per cycle
	////////////////////////////////////////////////////////////////////////////
	assign commit_valid = (count != 0) && done[head];
	assign commit_reg   = dest[head];
	assign commit_tag   = head;
	assign commit_data  = data[head];

	a_cdb_allocated: assert property (@(posedge clk) disable iff (!arst_n)
		cdb.valid |-> tag_t'(cdb.tag - head) < count);
endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module cdb_arbiter import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	issue_if.arbiter           iss,
	input  logic [`DATA_W-1:0] alu_data,
	input  logic [`DATA_W-1:0] mul_data,
	output cdb_t               cdb
);
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		slot_e slot;
	} rsv_t;

	rsv_t rsv [`MUL_LAT];
	logic mul_fire;
	logic alu_fire;

	// alu waits while slot 1 is about to move into slot 0
	assign iss.ready = (iss.op == OP_MUL) || !rsv[1].valid;
	assign mul_fire  = iss.valid && iss.ready && iss.op == OP_MUL;
	assign alu_fire  = iss.valid && iss.ready && iss.op != OP_MUL;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MUL_LAT; i++)
				rsv[i] <= '0;
		end else begin
			for (int i = 0; i < `MUL_LAT-1; i++)
				rsv[i] <= rsv[i+1];
			rsv[`MUL_LAT-1] <= '{valid: mul_fire, tag: iss.tag, slot: SLOT_MUL};
			if (alu_fire)
				rsv[0] <= '{valid: 1'b1, tag: iss.tag, slot: SLOT_ALU};
		end
	end

	assign cdb.valid = rsv[0].valid;
	assign cdb.tag   = rsv[0].tag;
	assign cdb.data  = (rsv[0].slot == SLOT_MUL) ? mul_data : alu_data;

	// a multiply still owns the bus slot it reserved
	a_near_slot_once: assert property (@(posedge clk) disable iff (!arst_n)
		mul_fire |-> ##`MUL_LAT cdb.valid && rsv[0].slot == SLOT_MUL
			&& cdb.tag == $past(iss.tag, `MUL_LAT));
endmodule

/* exec_units.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module exec_units import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	issue_if.monitor           iss,
	output logic [`DATA_W-1:0] alu_data,
	output logic [`DATA_W-1:0] mul_data
);
	logic [`DATA_W-1:0] mul_pipe [`MUL_LAT];
	logic               alu_fire;

	assign alu_fire = iss.valid && iss.ready && iss.op != OP_MUL;

	// single cycle alu, result sits on the bus the next cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu_data <= '0;
		end else if (alu_fire) begin
			case (iss.op)
				OP_SUB:  alu_data <= iss.opa - iss.opb;
				OP_MOVI: alu_data <= iss.opa;
				default: alu_data <= iss.opa + iss.opb;
			endcase
		end
	end

	// low product word, the arbiter knows which stage holds a live result
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `MUL_LAT; i++)
				mul_pipe[i] <= '0;
		end else begin
			mul_pipe[0] <= iss.opa * iss.opb;
			for (int i = 1; i < `MUL_LAT; i++)
				mul_pipe[i] <= mul_pipe[i-1];
		end
	end

	assign mul_data = mul_pipe[`MUL_LAT-1];
endmodule

/* reg_status.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module reg_status import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [`REG_W-1:0]  rs1,
	input  logic [`REG_W-1:0]  rs2,
	output logic [`DATA_W-1:0] src_val [2],
	output logic               src_pend [2],
	output tag_t               src_tag [2],
	input  logic               issue,
	input  logic [`REG_W-1:0]  issue_rd,
	input  tag_t               issue_tag,
	input  logic               commit,
	input  logic [`REG_W-1:0]  commit_reg,
	input  tag_t               commit_tag,
	input  logic [`DATA_W-1:0] commit_data
);
	logic [`DATA_W-1:0] regs [`REG_N];
	logic               pend [`REG_N];
	tag_t               last_tag [`REG_N];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_N; i++) begin
				regs[i] <= '0;
				pend[i] <= 1'b0;
			end
		end else begin
			if (commit) begin
				regs[commit_reg] <= commit_data;
				// an older commit leaves a newer producer pending
				if (last_tag[commit_reg] == commit_tag)
					pend[commit_reg] <= 1'b0;
			end
			if (issue)
				pend[issue_rd] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			last_tag[issue_rd] <= issue_tag;
	end

	assign src_val[0]  = regs[rs1];
	assign src_val[1]  = regs[rs2];
	assign src_pend[0] = pend[rs1];
	assign src_pend[1] = pend[rs2];
	assign src_tag[0]  = last_tag[rs1];
	assign src_tag[1]  = last_tag[rs2];
endmodule

/* issue_decode.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

module issue_decode import core_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               inst_valid,
	input  inst_t              inst,
	output logic               inst_ready,
	issue_if.decode            iss,
	input  cdb_t               cdb,
	output logic [`REG_W-1:0]  rs1,
	output logic [`REG_W-1:0]  rs2,
	input  logic [`DATA_W-1:0] src_val [2],
	input  logic               src_pend [2],
	input  tag_t               src_tag [2],
	input  logic               rob_full,
	input  tag_t               rob_tail,
	input  logic               rob_done [2],
	input  logic [`DATA_W-1:0] rob_data [2],
	output logic               alloc,
	output logic [`REG_W-1:0]  alloc_rd
);
	opcode_e            op;
	logic [`DATA_W-1:0] imm_ext;
	logic [`DATA_W-1:0] val [2];
	logic [1:0]         known;
	logic [`ROB_W:0]    issued_cnt;

	// unknown opcodes run as add
	always_comb begin
		case (inst.opcode)
			OP_SUB:  op = OP_SUB;
			OP_MOVI: op = OP_MOVI;
			OP_MUL:  op = OP_MUL;
			default: op = OP_ADD;
		endcase
	end

	assign imm_ext = {{(`DATA_W-16){inst.imm[15]}}, inst.imm};
	assign rs1 = inst.rs1;
	assign rs2 = inst.rs2;

	// register file first, then the bus this cycle, then a finished rob entry
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			if (!src_pend[i]) begin
				known[i] = 1'b1;
				val[i]   = src_val[i];
			end else if (cdb.valid && cdb.tag == src_tag[i]) begin
				known[i] = 1'b1;
				val[i]   = cdb.data;
			end else begin
				known[i] = rob_done[i];
				val[i]   = rob_data[i];
			end
		end
	end

	assign iss.op    = op;
	assign iss.tag   = rob_tail;
	assign iss.opa   = (op == OP_MOVI) ? imm_ext : val[0];
	assign iss.opb   = (op == OP_MOVI) ? '0 : val[1];
	assign iss.valid = inst_valid && !rob_full && (op == OP_MOVI || known == 2'b11);

	assign alloc      = iss.valid && iss.ready;
	assign alloc_rd   = inst.rd;
	assign inst_ready = alloc;

	// saturates once the buffer could have filled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issued_cnt <= '0;
		end else if (alloc && issued_cnt != `ROB_DEPTH) begin
			issued_cnt <= issued_cnt + 1'b1;
		end
	end

	a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n)
		rob_full |-> !alloc && issued_cnt == `ROB_DEPTH);
endmodule

/* issue_if.sv */
`timescale 1ns/1ps
`include "core_defs.svh"

interface issue_if import core_pkg::*; ();
	logic               valid;
	logic               ready;
	opcode_e            op;
	tag_t               tag;
	logic [`DATA_W-1:0] opa;
	logic [`DATA_W-1:0] opb;

	modport decode (
		output valid, op, tag, opa, opb,
		input  ready
	);

	// ready comes from the result bus slot check
	modport arbiter (
		input  valid, op, tag,
		output ready
	);

	modport monitor (
		input valid, ready, op, opa, opb
	);
endinterface

/* core_pkg.sv */
`include "core_defs.svh"

package core_pkg;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_MOVI = 4'h2,
		OP_MUL  = 4'h3
	} opcode_e;

	// instruction word layout
	typedef struct packed {
		logic [3:0]        opcode;
		logic [`REG_W-1:0] rd;
		logic [`REG_W-1:0] rs1;
		logic [`REG_W-1:0] rs2;
		logic [15:0]       imm;
	} inst_t;

	typedef logic [`ROB_W-1:0] tag_t;

	typedef struct packed {
		logic               valid;
		tag_t               tag;
		logic [`DATA_W-1:0] data;
	} cdb_t;

	typedef enum logic {SLOT_ALU, SLOT_MUL} slot_e;

endpackage

/* core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath
`define DATA_W 32

// architectural registers
`define REG_N 16
`define REG_W 4

// reorder buffer, tag width follows depth
`define ROB_DEPTH 8
`define ROB_W 3

`define MUL_LAT 3

`endif
